// File: hdl/dispatchFmtPkg.sv
// Dispatch instruction format
// Field widths of a renamed instruction and the instruction class
// carried with every dispatch lane

package dispatchFmtPkg;

  // Instruction address width
  localparam int PcWidth    = 32;

  // Logical register number width
  localparam int LogRegLog  = 5;

  // Physical register number width
  localparam int PhysRegLog = 7;

  // Load and store are exclusive, so one class field replaces two flags
  typedef enum logic [1:0] {
    IcOther = 2'b00,  // ALU, branch and everything else
    IcLoad  = 2'b01,  // Takes a load queue entry
    IcStore = 2'b10   // Takes a store queue entry
  } instrClassE;      // Code 2'b11 is illegal

endpackage

// File: hdl/dispatchCfgPkg.sv
// Dispatch configuration defaults
// Lane count, branch checkpoint count and back-end queue sizes
// that seed the module parameters of the dispatch stage

package dispatchCfgPkg;

  // Lanes per bundle
  localparam int DefDispatchWidth  = 4;

  // Branch checkpoints in flight
  localparam int DefCheckpoints    = 8;

  // Load queue and store queue share one size
  localparam int DefLsqSize        = 16;

  // Issue queue entries
  localparam int DefIssueQSize     = 32;

  // Active list entries
  localparam int DefActiveListSize = 64;

endpackage

// File: hdl/capacityCheck.sv
// Back-end capacity checker
// Counts the loads and stores of a bundle and tests whether the
// load queue, store queue, issue queue and active list can take it

`timescale 1ns/1ns

module capacityCheck #(
  parameter int DispatchWidth  = dispatchCfgPkg::DefDispatchWidth,
  parameter int LsqSize        = dispatchCfgPkg::DefLsqSize,
  parameter int IssueQSize     = dispatchCfgPkg::DefIssueQSize,
  parameter int ActiveListSize = dispatchCfgPkg::DefActiveListSize
) (
  input  dispatchFmtPkg::instrClassE [DispatchWidth-1:0] instrClass_i,
  input  logic [$clog2(LsqSize):0]                       loadQueueCnt_i,
  input  logic [$clog2(LsqSize):0]                       storeQueueCnt_i,
  input  logic [$clog2(IssueQSize):0]                    issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize):0]                activeListCnt_i,
  output logic                                           backEndFull_o
);
  import dispatchFmtPkg::*;

  localparam int LaneCntW = $clog2(DispatchWidth + 1);
  // One spare lane-count width on top of each count, so sums never wrap
  localparam int LsqSumW  = $clog2(LsqSize) + 1 + LaneCntW;
  localparam int IqSumW   = $clog2(IssueQSize) + 1 + LaneCntW;
  localparam int AlSumW   = $clog2(ActiveListSize) + 1 + LaneCntW;

  logic [LaneCntW-1:0] loadCnt;
  logic [LaneCntW-1:0] storeCnt;
  logic [LsqSumW-1:0]  loadSum;
  logic [LsqSumW-1:0]  storeSum;
  logic [IqSumW-1:0]   iqSum;
  logic [AlSumW-1:0]   alSum;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      if (instrClass_i[lane] == IcLoad) begin
        loadCnt = loadCnt + LaneCntW'(1);
      end
      if (instrClass_i[lane] == IcStore) begin
        storeCnt = storeCnt + LaneCntW'(1);
      end
    end
  end

  assign loadSum  = LsqSumW'(loadQueueCnt_i) + LsqSumW'(loadCnt);
  assign storeSum = LsqSumW'(storeQueueCnt_i) + LsqSumW'(storeCnt);
  // Every lane takes an issue queue and an active list slot
  assign iqSum    = IqSumW'(issueQueueCnt_i) + IqSumW'(DispatchWidth);
  assign alSum    = AlSumW'(activeListCnt_i) + AlSumW'(DispatchWidth);

  assign backEndFull_o = (loadSum  > LsqSumW'(LsqSize))    |
                         (storeSum > LsqSumW'(LsqSize))    |
                         (iqSum    > IqSumW'(IssueQSize))  |
                         (alSum    > AlSumW'(ActiveListSize));

endmodule

// File: hdl/branchMaskUpdate.sv
// Branch mask updater
// Clears the checkpoint of a just-verified branch from every lane's
// mask, so dispatched instructions stop depending on a resolved branch

`timescale 1ns/1ns

module branchMaskUpdate #(
  parameter int   DispatchWidth = dispatchCfgPkg::DefDispatchWidth,
  parameter int   Checkpoints   = dispatchCfgPkg::DefCheckpoints,
  localparam int  CkptLog       = $clog2(Checkpoints)
) (
  input  logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_i,
  input  logic                                      ctrlVerified_i,
  input  logic [CkptLog-1:0]                        ctrlVerifiedSMTid_i,
  output logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_o
);

  logic [Checkpoints-1:0] clearMask;

  // One-hot of the verified checkpoint or zero when nothing resolved
  assign clearMask = ctrlVerified_i ? (Checkpoints'(1) << ctrlVerifiedSMTid_i)
                                    : '0;

  for (genvar lane = 0; lane < DispatchWidth; lane++) begin : genLane
    assign branchMask_o[lane] = branchMask_i[lane] & ~clearMask;
  end

endmodule

// File: hdl/dispatchRegister.sv
// Dispatch register
// Forms the accept condition from rename readiness, stall, recovery and
// back-end capacity, then registers the bundle and presents it as the
// issue queue, active list and load-store queue payloads

`timescale 1ns/1ns

module dispatchRegister #(
  parameter int  DispatchWidth = dispatchCfgPkg::DefDispatchWidth,
  parameter int  Checkpoints   = dispatchCfgPkg::DefCheckpoints,
  localparam int CkptLog       = $clog2(Checkpoints)
) (
  input  logic                                                   clk,
  input  logic                                                   rstN_i,
  input  logic                                                   renameReady_i,
  input  logic                                                   stall_i,
  input  logic                                                   flagRecoverEX_i,
  input  logic                                                   backEndFull_i,
  input  dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         instrClass_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PcWidth-1:0]    pc_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::LogRegLog-1:0]  logDest_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] physDest_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] physSrc1_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] physSrc2_i,
  input  logic [DispatchWidth-1:0][CkptLog-1:0]                  checkpointId_i,
  input  logic [DispatchWidth-1:0][Checkpoints-1:0]              branchMask_i,
  output logic                                                   backEndReady_o,
  output logic                                                   stallFrontEnd_o,
  output logic                                                   dispatchValid_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] iqPhysDest_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] iqPhysSrc1_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] iqPhysSrc2_o,
  output logic [DispatchWidth-1:0][CkptLog-1:0]                  iqCheckpointId_o,
  output logic [DispatchWidth-1:0][Checkpoints-1:0]              iqBranchMask_o,
  output dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         iqInstrClass_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PcWidth-1:0]    alPc_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::LogRegLog-1:0]  alLogDest_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] alPhysDest_o,
  output dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         alInstrClass_o,
  output logic [DispatchWidth-1:0][Checkpoints-1:0]              lsqBranchMask_o,
  output dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         lsqInstrClass_o
);
  import dispatchFmtPkg::*;

  logic                                       accept;
  logic                                       validQ;
  instrClassE [DispatchWidth-1:0]             classQ;
  logic [DispatchWidth-1:0][PcWidth-1:0]      pcQ;
  logic [DispatchWidth-1:0][LogRegLog-1:0]    logDestQ;
  logic [DispatchWidth-1:0][PhysRegLog-1:0]   physDestQ;
  logic [DispatchWidth-1:0][PhysRegLog-1:0]   physSrc1Q;
  logic [DispatchWidth-1:0][PhysRegLog-1:0]   physSrc2Q;
  logic [DispatchWidth-1:0][CkptLog-1:0]      ckptIdQ;
  logic [DispatchWidth-1:0][Checkpoints-1:0]  branchMaskQ;

  assign backEndReady_o  = renameReady_i & ~backEndFull_i & ~flagRecoverEX_i;
  assign stallFrontEnd_o = backEndFull_i;
  assign accept          = backEndReady_o & ~stall_i;  // Whole bundle or nothing

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      validQ      <= 1'b0;
      pcQ         <= '0;
      logDestQ    <= '0;
      physDestQ   <= '0;
      physSrc1Q   <= '0;
      physSrc2Q   <= '0;
      ckptIdQ     <= '0;
      branchMaskQ <= '0;
      for (int lane = 0; lane < DispatchWidth; lane++) begin
        classQ[lane] <= IcOther;
      end
    end else begin
      validQ <= accept;  // High for exactly one cycle per bundle
      if (accept) begin
        classQ      <= instrClass_i;
        pcQ         <= pc_i;
        logDestQ    <= logDest_i;
        physDestQ   <= physDest_i;
        physSrc1Q   <= physSrc1_i;
        physSrc2Q   <= physSrc2_i;
        ckptIdQ     <= checkpointId_i;
        branchMaskQ <= branchMask_i;  // Already cleared of the verified branch
      end
    end
  end

  assign dispatchValid_o  = validQ;

  // Issue queue needs operands, destination and branch tracking
  assign iqPhysDest_o     = physDestQ;
  assign iqPhysSrc1_o     = physSrc1Q;
  assign iqPhysSrc2_o     = physSrc2Q;
  assign iqCheckpointId_o = ckptIdQ;
  assign iqBranchMask_o   = branchMaskQ;
  assign iqInstrClass_o   = classQ;

  // Active list keeps what retirement and rollback need
  assign alPc_o           = pcQ;
  assign alLogDest_o      = logDestQ;
  assign alPhysDest_o     = physDestQ;
  assign alInstrClass_o   = classQ;

  assign lsqBranchMask_o  = branchMaskQ;
  assign lsqInstrClass_o  = classQ;  // Selects load or store queue entry

endmodule

// File: hdl/dispatchStage.sv
// Dispatch stage top level
// Checks back-end capacity and updates branch masks side by side, then
// registers accepted bundles into the three back-end payloads

`timescale 1ns/1ns

module dispatchStage #(
  parameter int  DispatchWidth  = dispatchCfgPkg::DefDispatchWidth,
  parameter int  Checkpoints    = dispatchCfgPkg::DefCheckpoints,
  parameter int  LsqSize        = dispatchCfgPkg::DefLsqSize,
  parameter int  IssueQSize     = dispatchCfgPkg::DefIssueQSize,
  parameter int  ActiveListSize = dispatchCfgPkg::DefActiveListSize,
  localparam int CkptLog        = $clog2(Checkpoints)
) (
  input  logic                                                   clk,
  input  logic                                                   rstN_i,
  input  logic                                                   renameReady_i,
  input  dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         instrClass_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PcWidth-1:0]    pc_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::LogRegLog-1:0]  logDest_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] physDest_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] physSrc1_i,
  input  logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] physSrc2_i,
  input  logic [DispatchWidth-1:0][CkptLog-1:0]                  checkpointId_i,
  input  logic [DispatchWidth-1:0][Checkpoints-1:0]              branchMask_i,
  input  logic                                                   stall_i,
  input  logic                                                   flagRecoverEX_i,
  input  logic                                                   ctrlVerified_i,
  input  logic [CkptLog-1:0]                                     ctrlVerifiedSMTid_i,
  input  logic [$clog2(LsqSize):0]                               loadQueueCnt_i,
  input  logic [$clog2(LsqSize):0]                               storeQueueCnt_i,
  input  logic [$clog2(IssueQSize):0]                            issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize):0]                        activeListCnt_i,
  output logic                                                   backEndReady_o,
  output logic                                                   stallFrontEnd_o,
  output logic                                                   dispatchValid_o,
  output logic [DispatchWidth-1:0][Checkpoints-1:0]              updatedBranchMask_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] iqPhysDest_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] iqPhysSrc1_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] iqPhysSrc2_o,
  output logic [DispatchWidth-1:0][CkptLog-1:0]                  iqCheckpointId_o,
  output logic [DispatchWidth-1:0][Checkpoints-1:0]              iqBranchMask_o,
  output dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         iqInstrClass_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PcWidth-1:0]    alPc_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::LogRegLog-1:0]  alLogDest_o,
  output logic [DispatchWidth-1:0][dispatchFmtPkg::PhysRegLog-1:0] alPhysDest_o,
  output dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         alInstrClass_o,
  output logic [DispatchWidth-1:0][Checkpoints-1:0]              lsqBranchMask_o,
  output dispatchFmtPkg::instrClassE [DispatchWidth-1:0]         lsqInstrClass_o
);

  logic backEndFull;

  capacityCheck #(
    .DispatchWidth (DispatchWidth),
    .LsqSize       (LsqSize),
    .IssueQSize    (IssueQSize),
    .ActiveListSize(ActiveListSize)
  ) uCapacityCheck (
    .instrClass_i   (instrClass_i),
    .loadQueueCnt_i (loadQueueCnt_i),
    .storeQueueCnt_i(storeQueueCnt_i),
    .issueQueueCnt_i(issueQueueCnt_i),
    .activeListCnt_i(activeListCnt_i),
    .backEndFull_o  (backEndFull)
  );

  // Updated masks also go back to the rename pipeline register
  branchMaskUpdate #(
    .DispatchWidth(DispatchWidth),
    .Checkpoints  (Checkpoints)
  ) uBranchMaskUpdate (
    .branchMask_i       (branchMask_i),
    .ctrlVerified_i     (ctrlVerified_i),
    .ctrlVerifiedSMTid_i(ctrlVerifiedSMTid_i),
    .branchMask_o       (updatedBranchMask_o)
  );

  dispatchRegister #(
    .DispatchWidth(DispatchWidth),
    .Checkpoints  (Checkpoints)
  ) uDispatchRegister (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .renameReady_i   (renameReady_i),
    .stall_i         (stall_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .backEndFull_i   (backEndFull),
    .instrClass_i    (instrClass_i),
    .pc_i            (pc_i),
    .logDest_i       (logDest_i),
    .physDest_i      (physDest_i),
    .physSrc1_i      (physSrc1_i),
    .physSrc2_i      (physSrc2_i),
    .checkpointId_i  (checkpointId_i),
    .branchMask_i    (updatedBranchMask_o),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o),
    .dispatchValid_o (dispatchValid_o),
    .iqPhysDest_o    (iqPhysDest_o),
    .iqPhysSrc1_o    (iqPhysSrc1_o),
    .iqPhysSrc2_o    (iqPhysSrc2_o),
    .iqCheckpointId_o(iqCheckpointId_o),
    .iqBranchMask_o  (iqBranchMask_o),
    .iqInstrClass_o  (iqInstrClass_o),
    .alPc_o          (alPc_o),
    .alLogDest_o     (alLogDest_o),
    .alPhysDest_o    (alPhysDest_o),
    .alInstrClass_o  (alInstrClass_o),
    .lsqBranchMask_o (lsqBranchMask_o),
    .lsqInstrClass_o (lsqInstrClass_o)
  );

endmodule

// File: sim/dispatchStage_props.sv
// Dispatch stage properties
// Concurrent checks on the top-level ports of the dispatch stage

`timescale 1ns/1ns

module dispatchStageProps #(
  parameter int DispatchWidth = dispatchCfgPkg::DefDispatchWidth
) (
  input logic                                           clk,
  input logic                                           rstN_i,
  input logic                                           renameReady_i,
  input logic                                           stall_i,
  input logic                                           backEndReady_i,
  input logic                                           stallFrontEnd_i,
  input logic                                           dispatchValid_i,
  input logic                                           countsZero_i,
  input dispatchFmtPkg::instrClassE [DispatchWidth-1:0] instrClass_i
);
  import dispatchFmtPkg::*;

  logic illegalClass;

  always_comb begin
    illegalClass = 1'b0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      if (!(instrClass_i[lane] inside {IcOther, IcLoad, IcStore})) begin
        illegalClass = 1'b1;
      end
    end
  end

  noValidAfterRefusal: assert property (@(posedge clk) disable iff (!rstN_i)
    !(backEndReady_i && !stall_i) |=> !dispatchValid_i)
    else $error("dispatchValid_o high after an edge that refused the bundle");

  // Empty queues always have room for a full bundle
  noStallWhenEmpty: assert property (@(posedge clk) disable iff (!rstN_i)
    countsZero_i |-> !stallFrontEnd_i)
    else $error("stallFrontEnd_o high while every queue count is zero");

  legalClassWhenReady: assert property (@(posedge clk) disable iff (!rstN_i)
    renameReady_i |-> !illegalClass)
    else $error("illegal instruction class presented with renameReady_i");

endmodule

bind dispatchStage dispatchStageProps #(
  .DispatchWidth(DispatchWidth)
) uProps (
  .clk            (clk),
  .rstN_i         (rstN_i),
  .renameReady_i  (renameReady_i),
  .stall_i        (stall_i),
  .backEndReady_i (backEndReady_o),
  .stallFrontEnd_i(stallFrontEnd_o),
  .dispatchValid_i(dispatchValid_o),
  .countsZero_i   ((loadQueueCnt_i == '0) && (storeQueueCnt_i == '0) &&
                   (issueQueueCnt_i == '0) && (activeListCnt_i == '0)),
  .instrClass_i   (instrClass_i)
);

// File: sim/tbDispatch.sv
// Dispatch stage testbench
// Drives random bundles from an xorshift generator, models the capacity,
// branch-mask and accept rules, and checks every output each cycle

`timescale 1ns/1ns

module tbDispatch;
  import dispatchFmtPkg::*;
  import dispatchCfgPkg::*;

  localparam int Dw            = DefDispatchWidth;
  localparam int Ckpts         = DefCheckpoints;
  localparam int CkptLog       = $clog2(Ckpts);
  localparam int LsqCntW       = $clog2(DefLsqSize) + 1;
  localparam int IqCntW        = $clog2(DefIssueQSize) + 1;
  localparam int AlCntW        = $clog2(DefActiveListSize) + 1;
  localparam int AcceptTimeout = 64;

  typedef struct packed {
    instrClassE [Dw-1:0]            cls;
    logic [Dw-1:0][PcWidth-1:0]     pc;
    logic [Dw-1:0][LogRegLog-1:0]   logDest;
    logic [Dw-1:0][PhysRegLog-1:0]  physDest;
    logic [Dw-1:0][PhysRegLog-1:0]  src1;
    logic [Dw-1:0][PhysRegLog-1:0]  src2;
    logic [Dw-1:0][CkptLog-1:0]     ckpt;
    logic [Dw-1:0][Ckpts-1:0]       mask;
  } bundleT;

  logic                           clk = 1'b0;
  logic                           rstN;
  logic                           renameReady;
  logic                           stall;
  logic                           flagRecover;
  logic                           ctrlVerified;
  logic [CkptLog-1:0]             verifiedId;
  logic [LsqCntW-1:0]             loadQueueCnt;
  logic [LsqCntW-1:0]             storeQueueCnt;
  logic [IqCntW-1:0]              issueQueueCnt;
  logic [AlCntW-1:0]              activeListCnt;
  bundleT                         cur;
  logic                           backEndReady;
  logic                           stallFrontEnd;
  logic                           dispatchValid;
  logic [Dw-1:0][Ckpts-1:0]       updatedMask;
  logic [Dw-1:0][PhysRegLog-1:0]  iqPhysDest;
  logic [Dw-1:0][PhysRegLog-1:0]  iqPhysSrc1;
  logic [Dw-1:0][PhysRegLog-1:0]  iqPhysSrc2;
  logic [Dw-1:0][CkptLog-1:0]     iqCkpt;
  logic [Dw-1:0][Ckpts-1:0]       iqMask;
  instrClassE [Dw-1:0]            iqClass;
  logic [Dw-1:0][PcWidth-1:0]     alPc;
  logic [Dw-1:0][LogRegLog-1:0]   alLogDest;
  logic [Dw-1:0][PhysRegLog-1:0]  alPhysDest;
  instrClassE [Dw-1:0]            alClass;
  logic [Dw-1:0][Ckpts-1:0]       lsqMask;
  instrClassE [Dw-1:0]            lsqClass;

  logic [31:0] rngState = 32'hce9f_9776;
  bundleT      expReg;
  bundleT      expQ[$];  // Accepted bundles waiting for their edge
  logic        expValid;
  logic        nextValid;
  logic        newBundle;
  int          checks;
  int          errors;
  bit          timedOut;

  always #4 clk = ~clk;

  dispatchStage UUT (
    .clk(clk), .rstN_i(rstN), .renameReady_i(renameReady),
    .instrClass_i(cur.cls), .pc_i(cur.pc), .logDest_i(cur.logDest),
    .physDest_i(cur.physDest), .physSrc1_i(cur.src1), .physSrc2_i(cur.src2),
    .checkpointId_i(cur.ckpt), .branchMask_i(cur.mask),
    .stall_i(stall), .flagRecoverEX_i(flagRecover), .ctrlVerified_i(ctrlVerified),
    .ctrlVerifiedSMTid_i(verifiedId), .loadQueueCnt_i(loadQueueCnt),
    .storeQueueCnt_i(storeQueueCnt), .issueQueueCnt_i(issueQueueCnt),
    .activeListCnt_i(activeListCnt), .backEndReady_o(backEndReady),
    .stallFrontEnd_o(stallFrontEnd), .dispatchValid_o(dispatchValid),
    .updatedBranchMask_o(updatedMask), .iqPhysDest_o(iqPhysDest),
    .iqPhysSrc1_o(iqPhysSrc1), .iqPhysSrc2_o(iqPhysSrc2), .iqCheckpointId_o(iqCkpt),
    .iqBranchMask_o(iqMask), .iqInstrClass_o(iqClass), .alPc_o(alPc),
    .alLogDest_o(alLogDest), .alPhysDest_o(alPhysDest), .alInstrClass_o(alClass),
    .lsqBranchMask_o(lsqMask), .lsqInstrClass_o(lsqClass)
  );

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // Drop the verified checkpoint from every lane
  function automatic logic [Dw-1:0][Ckpts-1:0] clearVerified(input logic [Dw-1:0][Ckpts-1:0] m);
    logic [Dw-1:0][Ckpts-1:0] res;
    res = m;
    for (int l = 0; l < Dw; l++) begin
      for (int b = 0; b < Ckpts; b++) begin
        if (ctrlVerified && verifiedId == CkptLog'(b)) begin
          res[l][b] = 1'b0;
        end
      end
    end
    return res;
  endfunction

  function automatic bit expectFull();
    int loads;
    int stores;
    loads  = 0;
    stores = 0;
    for (int l = 0; l < Dw; l++) begin
      if (cur.cls[l] == IcLoad) loads++;
      if (cur.cls[l] == IcStore) stores++;
    end
    return (int'(loadQueueCnt) + loads > DefLsqSize) ||
           (int'(storeQueueCnt) + stores > DefLsqSize) ||
           (int'(issueQueueCnt) + Dw > DefIssueQSize) ||
           (int'(activeListCnt) + Dw > DefActiveListSize);
  endfunction

  task automatic compareValue(input string name, input logic [127:0] expVal,
                              input logic [127:0] actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("ERROR %0t ns %s expected %h actual %h", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkRegistered();
    compareValue("dispatchValid_o", 128'(expValid), 128'(dispatchValid));
    compareValue("iqPhysDest_o", 128'(expReg.physDest), 128'(iqPhysDest));
    compareValue("iqPhysSrc1_o", 128'(expReg.src1), 128'(iqPhysSrc1));
    compareValue("iqPhysSrc2_o", 128'(expReg.src2), 128'(iqPhysSrc2));
    compareValue("iqCheckpointId_o", 128'(expReg.ckpt), 128'(iqCkpt));
    compareValue("iqBranchMask_o", 128'(expReg.mask), 128'(iqMask));
    compareValue("iqInstrClass_o", 128'(expReg.cls), 128'(iqClass));
    compareValue("alPc_o", 128'(expReg.pc), 128'(alPc));
    compareValue("alLogDest_o", 128'(expReg.logDest), 128'(alLogDest));
    compareValue("alPhysDest_o", 128'(expReg.physDest), 128'(alPhysDest));
    compareValue("alInstrClass_o", 128'(expReg.cls), 128'(alClass));
    compareValue("lsqBranchMask_o", 128'(expReg.mask), 128'(lsqMask));
    compareValue("lsqInstrClass_o", 128'(expReg.cls), 128'(lsqClass));
  endtask

  task automatic drawBundle();
    for (int l = 0; l < Dw; l++) begin
      cur.cls[l]      = instrClassE'(2'(nextRandom() % 32'd3));  // Never the illegal code
      cur.pc[l]       = nextRandom();
      cur.logDest[l]  = LogRegLog'(nextRandom());
      cur.physDest[l] = PhysRegLog'(nextRandom());
      cur.src1[l]     = PhysRegLog'(nextRandom());
      cur.src2[l]     = PhysRegLog'(nextRandom());
      cur.ckpt[l]     = CkptLog'(nextRandom());
      cur.mask[l]     = Ckpts'(nextRandom());
    end
  endtask

  // Checks the last edge, drives on the falling edge, then checks combinational outputs
  task automatic stepCycle(input bit nearFull, input int readyPct, input int stallPct,
                           input int recoverPct, output bit accepted);
    bit     expFull;
    bit     expReady;
    bundleT pushed;
    @(negedge clk);
    expValid = nextValid;
    if (expValid) expReg = expQ.pop_front();
    checkRegistered();
    if (newBundle) drawBundle();
    renameReady  = (nextRandom() % 100) < readyPct;
    stall        = (nextRandom() % 100) < stallPct;
    flagRecover  = (nextRandom() % 100) < recoverPct;
    ctrlVerified = (nextRandom() % 2) == 1;
    verifiedId   = CkptLog'(nextRandom());
    if (nearFull) begin
      loadQueueCnt  = LsqCntW'(DefLsqSize - nextRandom() % 5);
      storeQueueCnt = LsqCntW'(DefLsqSize - nextRandom() % 5);
      issueQueueCnt = IqCntW'(DefIssueQSize - Dw - 2 + nextRandom() % 5);
      activeListCnt = AlCntW'(DefActiveListSize - Dw - 2 + nextRandom() % 5);
    end else if ((nextRandom() % 16) == 0) begin
      loadQueueCnt  = '0;  // Empty back end
      storeQueueCnt = '0;
      issueQueueCnt = '0;
      activeListCnt = '0;
    end else begin
      loadQueueCnt  = LsqCntW'(nextRandom() % 8);
      storeQueueCnt = LsqCntW'(nextRandom() % 8);
      issueQueueCnt = IqCntW'(nextRandom() % 16);
      activeListCnt = AlCntW'(nextRandom() % 32);
    end
    #1;
    expFull  = expectFull();
    expReady = renameReady && !expFull && !flagRecover;
    compareValue("stallFrontEnd_o", 128'(expFull), 128'(stallFrontEnd));
    compareValue("backEndReady_o", 128'(expReady), 128'(backEndReady));
    compareValue("updatedBranchMask_o", 128'(clearVerified(cur.mask)), 128'(updatedMask));
    accepted  = expReady && !stall;
    nextValid = accepted;
    if (accepted) begin
      pushed      = cur;
      pushed.mask = clearVerified(cur.mask);
      expQ.push_back(pushed);
    end
    newBundle = accepted || !renameReady;  // Producer holds a bundle until it is taken
  endtask

  task automatic reportTest(input string name, input int chkBase, input int errBase);
    $display("test %-12s %0d checks, %0d errors", name, checks - chkBase, errors - errBase);
  endtask

  initial begin
    int chkBase;
    int errBase;
    int waited;
    bit acc;
    rstN = 1'b0;
    renameReady = 1'b0;
    stall = 1'b0;
    flagRecover = 1'b0;
    ctrlVerified = 1'b0;
    verifiedId = '0;
    loadQueueCnt = '0;
    storeQueueCnt = '0;
    issueQueueCnt = '0;
    activeListCnt = '0;
    cur = '0;
    expReg = '0;
    expValid = 1'b0;
    nextValid = 1'b0;
    newBundle = 1'b1;
    checks = 0;
    errors = 0;
    timedOut = 1'b0;

    chkBase = checks;
    errBase = errors;
    repeat (5) begin
      @(negedge clk);
      checkRegistered();
    end
    rstN = 1'b1;
    repeat (2) stepCycle(1'b0, 0, 0, 0, acc);
    reportTest("reset", chkBase, errBase);

    chkBase = checks;
    errBase = errors;
    repeat (300) stepCycle(1'b1, 80, 10, 5, acc);
    reportTest("capacity", chkBase, errBase);

    chkBase = checks;
    errBase = errors;
    repeat (300) stepCycle(1'b0, 90, 10, 0, acc);
    reportTest("branchMask", chkBase, errBase);

    chkBase = checks;
    errBase = errors;
    for (int b = 0; b < 100 && !timedOut; b++) begin
      waited = 0;
      acc = 1'b0;
      while (!acc && !timedOut) begin
        stepCycle(1'b0, 70, 20, 10, acc);
        waited++;
        if (!acc && waited >= AcceptTimeout) begin
          timedOut = 1'b1;
          $display("timeout: bundle not accepted within %0d cycles", AcceptTimeout);
        end
      end
    end
    reportTest("payload", chkBase, errBase);

    chkBase = checks;
    errBase = errors;
    repeat (200) stepCycle(1'b0, 90, 50, 30, acc);
    repeat (50) stepCycle(1'b0, 100, 0, 0, acc);  // Back to back with room everywhere
    stepCycle(1'b0, 0, 0, 0, acc);
    reportTest("backPressure", chkBase, errBase);

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timedOut) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/dispatchFmtPkg.sv
hdl/dispatchCfgPkg.sv
hdl/capacityCheck.sv
hdl/branchMaskUpdate.sv
hdl/dispatchRegister.sv
hdl/dispatchStage.sv
sim/dispatchStage_props.sv
sim/tbDispatch.sv

// File: Makefile
# Verilator build and run of the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= tbDispatch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
